/* build.f */
+incdir+.
tlb_pkg.sv
tlb_entry_store.sv
tlb_match.sv
tlb_maint_ctrl.sv
tlb_top.sv
tb_tlb.sv

/* run_sim.sh */
#!/bin/sh
# Build the TLB testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --timescale 1ns/1ps --top-module tb_tlb -f build.f -o tb_tlb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_tlb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see $LOG"
exit 1

/* tb_tlb.sv */
`default_nettype none

`include "tlb_settings.svh"

module tb_tlb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N         = `TLB_ENTRIES;
    localparam int RST_CYC   = 16;
    localparam int MAINT_CYC = 6;                     // Four-phase exchange plus one idle cycle
    localparam int LEN_RESET = MAINT_CYC + 10;
    localparam int LEN_RDWR  = (N + 24) * MAINT_CYC;
    localparam int LEN_4K    = 5 * MAINT_CYC + 18;
    localparam int LEN_2M    = 4 * MAINT_CYC + 18;
    localparam int LEN_SRCH  = (2 * N + 4) * MAINT_CYC;
    localparam int LEN_INV   = 4 * ((2 * N + 3) * MAINT_CYC + N + 1);
    localparam int TEST_CYC  = RST_CYC + LEN_RESET + LEN_RDWR + LEN_4K + LEN_2M
                               + LEN_SRCH + LEN_INV;

    logic                    clk = 1'b0;
    logic                    rst_n;
    tlb_pkg::tlb_xlat_req_t  xlat_req;
    tlb_pkg::tlb_xlat_rsp_t  xlat_rsp;
    logic                    maint_req;
    tlb_pkg::tlb_maint_req_t maint_req_data;
    logic                    maint_ack;
    tlb_pkg::tlb_maint_rsp_t maint_rsp;

    tlb_pkg::tlb_entry_t     model [N];               // Reference copy of the entry store
    tlb_pkg::tlb_xlat_rsp_t  exp_xlat;
    tlb_pkg::tlb_xlat_rsp_t  exp_xlat_q = '0;         // Prediction for the response now visible
    tlb_pkg::tlb_maint_rsp_t exp_maint;
    logic                    req_q = 1'b0;            // maint_req as the DUT sampled it
    logic                    chk_en = 1'b0;
    integer                  seed;
    int                      errors;
    int                      tests_passed;
    int                      tests_failed;

    always #20 clk = ~clk;

    tlb_top tlb_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .xlat_req       (xlat_req),
        .xlat_rsp       (xlat_rsp),
        .maint_req      (maint_req),
        .maint_req_data (maint_req_data),
        .maint_ack      (maint_ack),
        .maint_rsp      (maint_rsp)
    );

    always @(posedge clk) begin
        exp_xlat_q <= exp_xlat;
        req_q      <= maint_req;
        chk_en     <= rst_n;
    end

    // All checks sample on the falling edge, where DUT outputs are settled
    a_xlat_rsp: assert property (@(negedge clk) disable iff (!chk_en)
        xlat_rsp == exp_xlat_q)
        else begin
            errors++;
            $display("CHECK FAILED at %0t: xlat_rsp %h, expected %h", $time, xlat_rsp, exp_xlat_q);
        end

    a_maint_rsp: assert property (@(negedge clk) disable iff (!chk_en)
        $rose(maint_ack) |-> maint_rsp == exp_maint)
        else begin
            errors++;
            $display("CHECK FAILED at %0t: maint_rsp %h, expected %h", $time, maint_rsp, exp_maint);
        end

    a_ack_rise: assert property (@(negedge clk) disable iff (!chk_en)
        $rose(maint_ack) |-> $past(req_q, `TLB_MAINT_LAT) && !$past(req_q, `TLB_MAINT_LAT + 1))
        else begin
            errors++;
            $display("CHECK FAILED at %0t: ack not two cycles after the request", $time);
        end

    a_ack_fall: assert property (@(negedge clk) disable iff (!chk_en)
        $fell(req_q) == $fell(maint_ack))
        else begin
            errors++;
            $display("CHECK FAILED at %0t: ack did not fall with the request", $time);
        end

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic logic [5:0] rand_ps();
        return (rand32() % 2) ? `TLB_PS_2M : `TLB_PS_4K;
    endfunction

    function automatic logic page_match(input tlb_pkg::tlb_entry_t ent, input logic [31:0] va);
        if (ent.ps == `TLB_PS_2M) begin
            return ent.vpn2[18:9] == va[31:22];
        end
        return (ent.ps == `TLB_PS_4K) && (ent.vpn2 == va[31:13]);
    endfunction

    function automatic tlb_pkg::tlb_xlat_rsp_t predict_xlat(input logic [31:0] va,
                                                            input logic [7:0] asid);
        tlb_pkg::tlb_xlat_rsp_t r;
        tlb_pkg::tlb_page_t     pg;
        r       = '0;
        r.valid = 1'b1;
        for (int i = 0; i < N; i++) begin
            if (!r.hit && model[i].e && (model[i].g || model[i].asid == asid)
                    && page_match(model[i], va)) begin
                r.hit   = 1'b1;
                r.index = tlb_pkg::tlb_idx_t'(i);
                r.ps    = model[i].ps;
                if (model[i].ps == `TLB_PS_2M) begin
                    pg   = va[21] ? model[i].page1 : model[i].page0;
                    r.pa = {pg.pfn[19:9], va[20:0]};
                end else begin
                    pg   = va[12] ? model[i].page1 : model[i].page0;
                    r.pa = {pg.pfn, va[11:0]};
                end
                r.page = pg;
            end
        end
        return r;
    endfunction

    function automatic tlb_pkg::tlb_entry_t make_entry(input int idx, input logic [5:0] ps,
                                                       input logic [7:0] asid, input logic g);
        logic [95:0]         bits;
        tlb_pkg::tlb_entry_t ent;
        bits            = {rand32(), rand32(), rand32()};
        ent             = bits[$bits(tlb_pkg::tlb_entry_t)-1:0];
        ent.vpn2[18:14] = 5'(idx);                    // Each index owns its own VA region
        ent.ps          = ps;
        ent.asid        = asid;
        ent.g           = g;
        ent.e           = 1'b1;
        return ent;
    endfunction

    function automatic logic [31:0] va_in(input tlb_pkg::tlb_entry_t ent, input logic odd);
        logic [31:0] va;
        va = rand32();
        if (ent.ps == `TLB_PS_2M) begin
            va[31:22] = ent.vpn2[18:9];
            va[21]    = odd;
        end else begin
            va[31:13] = ent.vpn2;
            va[12]    = odd;
        end
        return va;
    endfunction

    task automatic translate(input logic [31:0] va, input logic [7:0] asid);
        @(negedge clk);
        xlat_req.valid = 1'b1;
        xlat_req.va    = va;
        xlat_req.asid  = asid;
        exp_xlat       = predict_xlat(va, asid);
    endtask

    task automatic xlat_idle();
        @(negedge clk);
        xlat_req = '0;
        exp_xlat = '0;
    endtask

    task automatic maint_exchange(input tlb_pkg::tlb_maint_req_t req,
                                  input tlb_pkg::tlb_maint_rsp_t exp);
        int waited;
        @(negedge clk);
        maint_req_data = req;
        exp_maint      = exp;
        maint_req      = 1'b1;
        waited         = 0;
        while (!maint_ack && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (!maint_ack) begin
            errors++;
            $display("Maintenance request at %0t was never acknowledged", $time);
        end
        maint_req = 1'b0;
        @(negedge clk);
        if (maint_ack) begin
            errors++;
            $display("Maintenance ack still high at %0t after the request dropped", $time);
        end
    endtask

    task automatic write_entry(input int idx, input tlb_pkg::tlb_entry_t ent);
        tlb_pkg::tlb_maint_req_t req;
        req        = '0;
        req.op     = tlb_pkg::op_write;
        req.index  = tlb_pkg::tlb_idx_t'(idx);
        req.entry  = ent;
        maint_exchange(req, '0);
        model[idx] = ent;
    endtask

    task automatic read_check(input int idx);
        tlb_pkg::tlb_maint_req_t req;
        tlb_pkg::tlb_maint_rsp_t exp;
        req       = '0;
        req.op    = tlb_pkg::op_read;
        req.index = tlb_pkg::tlb_idx_t'(idx);
        exp       = '0;
        exp.entry = model[idx];
        maint_exchange(req, exp);
    endtask

    task automatic search_check(input logic [31:0] va, input logic [7:0] asid);
        tlb_pkg::tlb_maint_req_t req;
        tlb_pkg::tlb_maint_rsp_t exp;
        tlb_pkg::tlb_xlat_rsp_t  x;
        req       = '0;
        req.op    = tlb_pkg::op_search;
        req.va    = va;
        req.asid  = asid;
        x         = predict_xlat(va, asid);            // Search follows the translation match rule
        exp       = '0;
        exp.found = x.hit;
        exp.index = x.index;
        maint_exchange(req, exp);
    endtask

    task automatic invalidate(input tlb_pkg::tlb_op_e op, input logic [7:0] asid,
                              input logic [31:0] va);
        tlb_pkg::tlb_maint_req_t req;
        logic                    clr;
        req      = '0;
        req.op   = op;
        req.asid = asid;
        req.va   = va;
        maint_exchange(req, '0);
        for (int i = 0; i < N; i++) begin
            case (op)
                tlb_pkg::op_inv_all:       clr = 1'b1;
                tlb_pkg::op_inv_nonglobal: clr = !model[i].g;
                tlb_pkg::op_inv_asid:      clr = !model[i].g && model[i].asid == asid;
                default: clr = !model[i].g && model[i].asid == asid && page_match(model[i], va);
            endcase
            if (clr) begin
                model[i].e = 1'b0;
            end
        end
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        if (errors == errs_at_start) begin
            tests_passed++;
            $display("PASS %0s", name);
        end else begin
            tests_failed++;
            $display("FAIL %0s with %0d errors", name, errors - errs_at_start);
        end
    endtask

    // Four entries three slots apart, the last one global
    task automatic check_pages(input logic [5:0] ps, input int first);
        int          idx;
        logic [31:0] va;
        for (int j = 0; j < 4; j++) begin
            idx = first + 3 * j;
            write_entry(idx, make_entry(idx, ps, 8'(8'h10 + idx), j == 3));
        end
        for (int j = 0; j < 4; j++) begin
            idx = first + 3 * j;
            for (int odd = 0; odd < 2; odd++) begin
                va = va_in(model[idx], odd[0]);
                translate(va, model[idx].asid);
                translate(va, model[idx].asid ^ 8'h80);  // Hits only on the global entry
            end
        end
        translate(rand32(), 8'h10);
        xlat_idle();
    endtask

    task automatic run_tests();
        int                e0;
        tlb_pkg::tlb_op_e  inv_ops [4];
        inv_ops[0] = tlb_pkg::op_inv_all;
        inv_ops[1] = tlb_pkg::op_inv_nonglobal;
        inv_ops[2] = tlb_pkg::op_inv_asid;
        inv_ops[3] = tlb_pkg::op_inv_asid_va;

        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            translate(rand32(), 8'(rand32()));
        end
        xlat_idle();
        search_check(rand32(), 8'(rand32()));
        end_test("reset state and ack timing", e0);

        e0 = errors;
        for (int i = 0; i < N; i++) begin
            write_entry(i, make_entry(i, rand_ps(), 8'(rand32()), rand32() % 4 == 0));
        end
        for (int i = 0; i < 24; i++) begin
            read_check(int'(rand32() % N));
        end
        end_test("write and read back", e0);

        e0 = errors;
        invalidate(tlb_pkg::op_inv_all, 8'h00, 32'h0);
        check_pages(`TLB_PS_4K, 3);
        end_test("4 KiB translation", e0);

        e0 = errors;
        check_pages(`TLB_PS_2M, 1);
        end_test("2 MiB translation", e0);

        e0 = errors;
        for (int i = 0; i < N; i++) begin
            if (model[i].e) begin
                search_check(va_in(model[i], rand32() % 2 == 0), model[i].asid);
                search_check(va_in(model[i], 1'b0), model[i].asid + 8'h01);
            end
        end
        for (int i = 0; i < 4; i++) begin
            search_check(rand32() & 32'h07ff_ffff, 8'(rand32()));  // Region of unused index 0
        end
        end_test("search", e0);

        e0 = errors;
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < N; i++) begin
                write_entry(i, make_entry(i, rand_ps(), 8'(1 + rand32() % 3), rand32() % 4 == 0));
            end
            write_entry(5, make_entry(5, rand_ps(), 8'd2, 1'b0));   // Page for the single-page clear
            invalidate(inv_ops[k], 8'd2, va_in(model[5], 1'b0));
            for (int i = 0; i < N; i++) begin
                translate(va_in(model[i], i[0]), model[i].asid);
            end
            xlat_idle();
            for (int i = 0; i < N; i++) begin
                read_check(i);
            end
            search_check(va_in(model[5], 1'b1), 8'd2);
        end
        end_test("invalidate operations", e0);
    endtask

    initial begin
        seed           = 32'hf5fc1d10;
        errors         = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        rst_n          = 1'b0;
        xlat_req       = '0;
        maint_req      = 1'b0;
        maint_req_data = '0;
        exp_xlat       = '0;
        exp_maint      = '0;
        for (int i = 0; i < N; i++) begin
            model[i] = '0;
        end
        repeat (RST_CYC) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        run_tests();
        @(negedge clk);
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (2 * TEST_CYC) @(posedge clk);
        $display("Timeout after %0d cycles, the tests did not complete", 2 * TEST_CYC);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* tlb_entry_store.sv */
`default_nettype none

`include "tlb_settings.svh"

module tlb_entry_store (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    // Write port
    input  wire logic                     we,
    input  wire tlb_pkg::tlb_idx_t        w_index,
    input  wire tlb_pkg::tlb_entry_t      w_entry,
    // Existence clear, one bit per entry
    input  wire tlb_pkg::tlb_mask_t       clear_mask,
    // Indexed read
    input  wire tlb_pkg::tlb_idx_t        r_index,
    output tlb_pkg::tlb_entry_t           r_entry,
    // Whole array for the parallel compare
    output tlb_pkg::tlb_entry_arr_t       all_entries
);

    tlb_pkg::tlb_entry_arr_t entries_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                entries_q[i].e <= 1'b0;               // Only e is defined after reset
            end
        end else begin
            if (we) begin
                entries_q[w_index] <= w_entry;
            end
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                if (clear_mask[i]) begin
                    entries_q[i].e <= 1'b0;
                end
            end
        end
    end

    assign r_entry     = entries_q[r_index];
    assign all_entries = entries_q;

    // The controller never writes an entry and invalidates it in the same cycle
    a_no_write_clear: assert property (
        @(posedge clk) disable iff (!rst_n)
        we |-> !clear_mask[w_index]
    );

endmodule

`default_nettype wire

/* tlb_maint_ctrl.sv */
`default_nettype none

`include "tlb_settings.svh"

module tlb_maint_ctrl (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    // Four-phase maintenance port
    input  wire logic                     maint_req,
    input  wire tlb_pkg::tlb_maint_req_t  maint_req_data,
    output logic                          maint_ack,
    output tlb_pkg::tlb_maint_rsp_t       maint_rsp,
    // Entry store
    output logic                          we,
    output tlb_pkg::tlb_idx_t             w_index,
    output tlb_pkg::tlb_entry_t           w_entry,
    output tlb_pkg::tlb_mask_t            clear_mask,
    output tlb_pkg::tlb_idx_t             r_index,
    input  wire tlb_pkg::tlb_entry_t      r_entry,
    input  wire tlb_pkg::tlb_entry_arr_t  all_entries,
    // Matcher compare port
    output logic [31:0]                   cmp_va,
    output logic [7:0]                    cmp_asid,
    output logic                          cmp_use_va,
    input  wire tlb_pkg::tlb_mask_t       cmp_hits
);

    typedef enum logic [1:0] {
        st_idle,
        st_exec,
        st_resp,
        st_ack
    } state_e;

    state_e             state_q;
    state_e             state_d;
    logic               exec;
    tlb_pkg::tlb_op_e   op;
    tlb_pkg::tlb_mask_t g_col;
    tlb_pkg::tlb_mask_t inv_mask;

    assign op   = maint_req_data.op;                  // Held stable while maint_req is high
    assign exec = (state_q == st_exec);

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: if (maint_req) state_d = st_exec;
            st_exec: state_d = st_resp;
            st_resp: state_d = st_ack;
            st_ack:  if (!maint_req) state_d = st_idle;  // Stall until requester lets go
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    assign maint_ack = (state_q == st_ack);

    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            g_col[i] = all_entries[i].g;
        end
    end

    // cmp_hits lets globals through, so every ASID-based clear masks them here
    always_comb begin
        case (op)
            tlb_pkg::op_inv_all:       inv_mask = '1;
            tlb_pkg::op_inv_nonglobal: inv_mask = ~g_col;
            tlb_pkg::op_inv_asid,
            tlb_pkg::op_inv_asid_va:   inv_mask = cmp_hits & ~g_col;
            default:                   inv_mask = '0;
        endcase
    end

    assign cmp_va     = maint_req_data.va;
    assign cmp_asid   = maint_req_data.asid;
    assign cmp_use_va = (op == tlb_pkg::op_search) || (op == tlb_pkg::op_inv_asid_va);

    assign we         = exec && (op == tlb_pkg::op_write);
    assign w_index    = maint_req_data.index;
    assign w_entry    = maint_req_data.entry;
    assign r_index    = maint_req_data.index;
    assign clear_mask = exec ? inv_mask : '0;

    always_ff @(posedge clk) begin
        if (exec) begin
            maint_rsp <= '0;
            case (op)
                tlb_pkg::op_read: begin
                    maint_rsp.entry <= r_entry;
                end
                tlb_pkg::op_search: begin
                    maint_rsp.found <= |cmp_hits;
                    maint_rsp.index <= tlb_pkg::first_hit(cmp_hits);
                end
                default: ;
            endcase
        end
    end

    // Ack is seen high one edge after it rose, so req is checked at the rising edge
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(maint_ack) |-> $past(maint_req)
    );

    a_req_data_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        maint_req && $past(maint_req) |-> $stable(maint_req_data)
    );

endmodule

`default_nettype wire

/* tlb_match.sv */
`default_nettype none

`include "tlb_settings.svh"

module tlb_match (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire tlb_pkg::tlb_entry_arr_t  all_entries,
    // Translation port, one cycle latency
    input  wire tlb_pkg::tlb_xlat_req_t   xlat_req,
    output tlb_pkg::tlb_xlat_rsp_t        xlat_rsp,
    // Maintenance compare port, combinational
    input  wire logic [31:0]              cmp_va,
    input  wire logic [7:0]               cmp_asid,
    input  wire logic                     cmp_use_va,
    output tlb_pkg::tlb_mask_t            cmp_hits
);

    tlb_pkg::tlb_mask_t  xlat_hits;
    logic                xlat_hit;
    tlb_pkg::tlb_idx_t   sel_idx;
    tlb_pkg::tlb_entry_t sel_ent;
    logic                sel_big;
    logic                sel_odd;
    tlb_pkg::tlb_page_t  sel_page;
    logic [31:0]         sel_pa;

    logic                valid_q;
    logic                hit_q;
    tlb_pkg::tlb_idx_t   idx_q;
    logic [31:0]         pa_q;
    tlb_pkg::tlb_page_t  page_q;
    logic [5:0]          ps_q;

    // A global entry matches any ASID
    function automatic logic entry_hit(
        input tlb_pkg::tlb_entry_t ent,
        input logic [7:0]          asid,
        input logic [31:0]         va,
        input logic                use_va
    );
        logic page_eq;
        case (ent.ps)
            `TLB_PS_4K: page_eq = (ent.vpn2 == va[31:13]);
            `TLB_PS_2M: page_eq = (ent.vpn2[18:9] == va[31:22]);
            default:    page_eq = 1'b0;
        endcase
        return ent.e && (ent.g || ent.asid == asid) && (!use_va || page_eq);
    endfunction

    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            xlat_hits[i] = entry_hit(all_entries[i], xlat_req.asid, xlat_req.va, 1'b1);
            cmp_hits[i]  = entry_hit(all_entries[i], cmp_asid, cmp_va, cmp_use_va);
        end
    end

    assign xlat_hit = xlat_req.valid && (|xlat_hits);
    assign sel_idx  = tlb_pkg::first_hit(xlat_hits);
    assign sel_ent  = all_entries[sel_idx];
    assign sel_big  = (sel_ent.ps == `TLB_PS_2M);
    assign sel_odd  = sel_big ? xlat_req.va[21] : xlat_req.va[12];     // Even/odd page
    assign sel_page = sel_odd ? sel_ent.page1 : sel_ent.page0;
    assign sel_pa   = sel_big ? {sel_page.pfn[19:9], xlat_req.va[20:0]}
                              : {sel_page.pfn, xlat_req.va[11:0]};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            hit_q   <= 1'b0;
        end else begin
            valid_q <= xlat_req.valid;
            hit_q   <= xlat_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (xlat_hit) begin
            idx_q  <= sel_idx;
            pa_q   <= sel_pa;
            page_q <= sel_page;
            ps_q   <= sel_ent.ps;
        end else begin
            idx_q  <= '0;                             // Miss reports zeros
            pa_q   <= '0;
            page_q <= '0;
            ps_q   <= '0;
        end
    end

    always_comb begin
        xlat_rsp.valid = valid_q;
        xlat_rsp.hit   = hit_q;
        xlat_rsp.index = idx_q;
        xlat_rsp.pa    = pa_q;
        xlat_rsp.page  = page_q;
        xlat_rsp.ps    = ps_q;
    end

    a_hit_entry_present: assert property (
        @(posedge clk) disable iff (!rst_n)
        hit_q |-> $past(all_entries[sel_idx].e)
    );

endmodule

`default_nettype wire

/* tlb_pkg.sv */
`default_nettype none

`include "tlb_settings.svh"

package tlb_pkg;

    typedef logic [`TLB_IDX_W-1:0]   tlb_idx_t;
    typedef logic [`TLB_ENTRIES-1:0] tlb_mask_t;   // One bit per entry

    typedef struct packed {
        logic [19:0] pfn;
        logic [1:0]  mat;
        logic [1:0]  plv;
        logic        d;
        logic        v;
    } tlb_page_t;

    typedef struct packed {
        logic [18:0] vpn2;                         // VA[31:13]
        logic [7:0]  asid;
        logic [5:0]  ps;
        logic        g;
        logic        e;
        tlb_page_t   page0;                        // Even page
        tlb_page_t   page1;                        // Odd page
    } tlb_entry_t;

    typedef tlb_entry_t [`TLB_ENTRIES-1:0] tlb_entry_arr_t;

    typedef enum logic [2:0] {
        op_read,
        op_write,
        op_search,
        op_inv_all,
        op_inv_nonglobal,
        op_inv_asid,
        op_inv_asid_va
    } tlb_op_e;

    typedef struct packed {
        tlb_op_e     op;
        tlb_idx_t    index;
        tlb_entry_t  entry;                        // Write data
        logic [7:0]  asid;
        logic [31:0] va;
    } tlb_maint_req_t;

    typedef struct packed {
        tlb_entry_t  entry;                        // Read data
        logic        found;
        tlb_idx_t    index;                        // Search result
    } tlb_maint_rsp_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] va;
        logic [7:0]  asid;
    } tlb_xlat_req_t;

    typedef struct packed {
        logic        valid;
        logic        hit;
        tlb_idx_t    index;
        logic [31:0] pa;
        tlb_page_t   page;
        logic [5:0]  ps;
    } tlb_xlat_rsp_t;

    // Lowest set bit wins
    function automatic tlb_idx_t first_hit(input tlb_mask_t hits);
        tlb_idx_t idx;
        idx = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hits[i]) begin
                idx = tlb_idx_t'(i);
            end
        end
        return idx;
    endfunction

endpackage

`default_nettype wire

/* tlb_settings.svh */
`ifndef TLB_SETTINGS_SVH
`define TLB_SETTINGS_SVH

`define TLB_ENTRIES   16                   // 8, 16 or 32 entries
`define TLB_IDX_W     $clog2(`TLB_ENTRIES)

`define TLB_PS_4K     6'd12                // Page size codes in the ps field
`define TLB_PS_2M     6'd21

`define TLB_MAINT_LAT 2                    // Sampled maint_req to maint_ack, in cycles

`endif

/* tlb_top.sv */
`default_nettype none

module tlb_top (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    // Translation port
    input  wire tlb_pkg::tlb_xlat_req_t   xlat_req,
    output tlb_pkg::tlb_xlat_rsp_t        xlat_rsp,
    // Maintenance port
    input  wire logic                     maint_req,
    input  wire tlb_pkg::tlb_maint_req_t  maint_req_data,
    output logic                          maint_ack,
    output tlb_pkg::tlb_maint_rsp_t       maint_rsp
);

    logic                    we;
    tlb_pkg::tlb_idx_t       w_index;
    tlb_pkg::tlb_entry_t     w_entry;
    tlb_pkg::tlb_mask_t      clear_mask;
    tlb_pkg::tlb_idx_t       r_index;
    tlb_pkg::tlb_entry_t     r_entry;
    tlb_pkg::tlb_entry_arr_t all_entries;
    logic [31:0]             cmp_va;
    logic [7:0]              cmp_asid;
    logic                    cmp_use_va;
    tlb_pkg::tlb_mask_t      cmp_hits;

    tlb_entry_store tlb_entry_store_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .we          (we),
        .w_index     (w_index),
        .w_entry     (w_entry),
        .clear_mask  (clear_mask),
        .r_index     (r_index),
        .r_entry     (r_entry),
        .all_entries (all_entries)
    );

    tlb_match tlb_match_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .all_entries (all_entries),
        .xlat_req    (xlat_req),
        .xlat_rsp    (xlat_rsp),
        .cmp_va      (cmp_va),
        .cmp_asid    (cmp_asid),
        .cmp_use_va  (cmp_use_va),
        .cmp_hits    (cmp_hits)
    );

    tlb_maint_ctrl tlb_maint_ctrl_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .maint_req      (maint_req),
        .maint_req_data (maint_req_data),
        .maint_ack      (maint_ack),
        .maint_rsp      (maint_rsp),
        .we             (we),
        .w_index        (w_index),
        .w_entry        (w_entry),
        .clear_mask     (clear_mask),
        .r_index        (r_index),
        .r_entry        (r_entry),
        .all_entries    (all_entries),
        .cmp_va         (cmp_va),
        .cmp_asid       (cmp_asid),
        .cmp_use_va     (cmp_use_va),
        .cmp_hits       (cmp_hits)
    );

endmodule

`default_nettype wire
